// File: source/scan_timing.sv
`timescale 1ns/1ps

module scan_timing #(
   parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE_DEFAULT,
   parameter int H_FRONT  = video_timing_pkg::H_FRONT_DEFAULT,
   parameter int H_SYNC   = video_timing_pkg::H_SYNC_DEFAULT,
   parameter int H_BACK   = video_timing_pkg::H_BACK_DEFAULT,
   parameter int V_ACTIVE = video_timing_pkg::V_ACTIVE_DEFAULT,
   parameter int V_FRONT  = video_timing_pkg::V_FRONT_DEFAULT,
   parameter int V_SYNC   = video_timing_pkg::V_SYNC_DEFAULT,
   parameter int V_BACK   = video_timing_pkg::V_BACK_DEFAULT
) (
   input  logic                      clk,
   input  logic                      reset,
   output video_timing_pkg::hcount_t hcount,
   output video_timing_pkg::vcount_t vcount,
   output logic                      hsync_n,
   output logic                      vsync_n,
   output logic                      active,
   output logic                      vga_clk
);

   localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
   localparam int V_SYNC_START = V_ACTIVE + V_FRONT;

   logic end_of_line;
   logic end_of_field;

   assign end_of_line  = hcount == video_timing_pkg::hcount_t'(H_TOTAL - 1);
   assign end_of_field = vcount == video_timing_pkg::vcount_t'(V_TOTAL - 1);

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         hcount <= '0;
      else if (end_of_line)
         hcount <= '0;
      else
         hcount <= hcount + 1'b1;
   end

   // Line counter steps once per line
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         vcount <= '0;
      else if (end_of_line) begin
         if (end_of_field)
            vcount <= '0;
         else
            vcount <= vcount + 1'b1;
      end
   end

   // Both syncs are active low
   assign hsync_n = !(hcount >= H_SYNC_START && hcount < H_SYNC_START + H_SYNC);
   assign vsync_n = !(vcount >= V_SYNC_START && vcount < V_SYNC_START + V_SYNC);

   assign active  = hcount < H_ACTIVE && vcount < V_ACTIVE;
   assign vga_clk = hcount[0];   // Half the system clock

endmodule

// File: source/sprite_compositor.sv
`timescale 1ns/1ps

module sprite_compositor #(
   parameter int N_SLOTS = 8
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic [N_SLOTS-1:0]                      hit,
   input  sprite_pkg::offset_t [N_SLOTS-1:0]       row,
   input  sprite_pkg::offset_t [N_SLOTS-1:0]       col,
   input  sprite_pkg::pattern_name_t [N_SLOTS-1:0] name,
   input  logic                                    hsync_n,
   input  logic                                    vsync_n,
   input  logic                                    active,
   output logic [7:0]                              VGA_R,
   output logic [7:0]                              VGA_G,
   output logic [7:0]                              VGA_B,
   output logic                                    VGA_HS,
   output logic                                    VGA_VS,
   output logic                                    VGA_BLANK_n
);

   `include "sprite_patterns.svh"

   logic                      any_hit;
   sprite_pkg::offset_t       sel_row;
   sprite_pkg::offset_t       sel_col;
   sprite_pkg::pattern_name_t sel_name;
   logic                      hsync_d;      // Aligned with the slot outputs
   logic                      vsync_d;
   logic                      active_d;
   logic                      sprite_q;
   logic [15:0]               row_bits_q;
   sprite_pkg::rgb_t          edge_q;
   sprite_pkg::rgb_t          fill_q;
   sprite_pkg::offset_t       col_q;
   logic [17:0]               window;
   sprite_pkg::rgb_t          pixel_rgb;

   // Highest slot index wins
   always_comb begin
      any_hit  = 1'b0;
      sel_row  = '0;
      sel_col  = '0;
      sel_name = '0;
      for (int i = 0; i < N_SLOTS; i++) begin
         if (hit[i]) begin
            any_hit  = 1'b1;
            sel_row  = row[i];
            sel_col  = col[i];
            sel_name = name[i];
         end
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         hsync_d     <= 1'b1;
         vsync_d     <= 1'b1;
         active_d    <= 1'b0;
         VGA_HS      <= 1'b1;
         VGA_VS      <= 1'b1;
         VGA_BLANK_n <= 1'b0;
         sprite_q    <= 1'b0;
      end else begin
         hsync_d     <= hsync_n;
         vsync_d     <= vsync_n;
         active_d    <= active;
         VGA_HS      <= hsync_d;
         VGA_VS      <= vsync_d;
         VGA_BLANK_n <= active_d;
         sprite_q    <= any_hit;
      end
   end

   always_ff @(posedge clk) begin
      col_q <= sel_col;
      if (sel_name < N_PATTERNS) begin
         row_bits_q <= pattern_rows[sel_name][sel_row];
         edge_q     <= edge_rgb[sel_name];
         fill_q     <= fill_rgb[sel_name];
      end else begin
         row_bits_q <= '0;   // Fully transparent where no pattern exists for the number
         edge_q     <= sprite_pkg::BACKGROUND_RGB;
         fill_q     <= sprite_pkg::BACKGROUND_RGB;
      end
   end

   // Bits 17, 16 and 15 become left neighbour, pixel and right neighbour
   assign window = {1'b0, row_bits_q, 1'b0} << col_q;

   always_comb begin
      if (!sprite_q || !window[16])
         pixel_rgb = sprite_pkg::BACKGROUND_RGB;
      else if (window[17] && window[15])
         pixel_rgb = fill_q;
      else
         pixel_rgb = edge_q;
   end

   assign {VGA_R, VGA_G, VGA_B} = VGA_BLANK_n ? pixel_rgb : '0;

endmodule

// File: source/sprite_display.sv
`timescale 1ns/1ps

module sprite_display #(
   parameter int N_SLOTS  = 8,
   parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE_DEFAULT,
   parameter int H_FRONT  = video_timing_pkg::H_FRONT_DEFAULT,
   parameter int H_SYNC   = video_timing_pkg::H_SYNC_DEFAULT,
   parameter int H_BACK   = video_timing_pkg::H_BACK_DEFAULT,
   parameter int V_ACTIVE = video_timing_pkg::V_ACTIVE_DEFAULT,
   parameter int V_FRONT  = video_timing_pkg::V_FRONT_DEFAULT,
   parameter int V_SYNC   = video_timing_pkg::V_SYNC_DEFAULT,
   parameter int V_BACK   = video_timing_pkg::V_BACK_DEFAULT
) (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  chipselect,
   input  logic                  write,
   input  sprite_pkg::reg_addr_t address,
   input  sprite_pkg::bus_data_t writedata,
   output logic [7:0]            VGA_R,
   output logic [7:0]            VGA_G,
   output logic [7:0]            VGA_B,
   output logic                  VGA_CLK,
   output logic                  VGA_HS,
   output logic                  VGA_VS,
   output logic                  VGA_BLANK_n
);

   video_timing_pkg::hcount_t               hcount;
   video_timing_pkg::vcount_t               vcount;
   logic                                    hsync_n;
   logic                                    vsync_n;
   logic                                    active;
   logic [N_SLOTS-1:0]                      commit;
   sprite_pkg::coord_t                      staged_x;
   sprite_pkg::coord_t                      staged_y;
   sprite_pkg::pattern_name_t               staged_name;
   logic                                    staged_enable;
   logic [N_SLOTS-1:0]                      hit;
   sprite_pkg::offset_t [N_SLOTS-1:0]       row;
   sprite_pkg::offset_t [N_SLOTS-1:0]       col;
   sprite_pkg::pattern_name_t [N_SLOTS-1:0] name;

   scan_timing #(
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) timing_inst (
      .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
      .hsync_n(hsync_n), .vsync_n(vsync_n), .active(active), .vga_clk(VGA_CLK)
   );

   sprite_registers #(.N_SLOTS(N_SLOTS)) registers_inst (
      .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
      .address(address), .writedata(writedata), .commit(commit),
      .staged_x(staged_x), .staged_y(staged_y), .staged_name(staged_name),
      .staged_enable(staged_enable)
   );

   // Each slot loads only on its own commit bit
   for (genvar i = 0; i < N_SLOTS; i++) begin : g_slot
      sprite_slot #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) slot_inst (
         .clk(clk), .reset(reset), .commit(commit[i]),
         .staged_x(staged_x), .staged_y(staged_y), .staged_name(staged_name),
         .staged_enable(staged_enable), .hcount(hcount), .vcount(vcount),
         .hit(hit[i]), .row(row[i]), .col(col[i]), .name(name[i])
      );
   end

   sprite_compositor #(.N_SLOTS(N_SLOTS)) compositor_inst (
      .clk(clk), .reset(reset), .hit(hit), .row(row), .col(col), .name(name),
      .hsync_n(hsync_n), .vsync_n(vsync_n), .active(active),
      .VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B),
      .VGA_HS(VGA_HS), .VGA_VS(VGA_VS), .VGA_BLANK_n(VGA_BLANK_n)
   );

endmodule

// File: source/sprite_patterns.svh
// Bit 15 of each row is the leftmost pixel
localparam int N_PATTERNS = 3;

localparam logic [15:0] pattern_rows [N_PATTERNS][16] = '{
   '{ // Ship
      16'b0000_0001_1000_0000,
      16'b0000_0001_1000_0000,
      16'b0000_0011_1100_0000,
      16'b0000_0011_1100_0000,
      16'b0000_0111_1110_0000,
      16'b0000_0110_0110_0000,
      16'b0000_1111_1111_0000,
      16'b0001_1111_1111_1000,
      16'b0011_1111_1111_1100,
      16'b0111_1111_1111_1110,
      16'b1111_1111_1111_1111,
      16'b1111_1111_1111_1111,
      16'b1111_0011_1100_1111,
      16'b1110_0001_1000_0111,
      16'b1100_0000_0000_0011,
      16'b1000_0000_0000_0001},
   '{ // Bird
      16'b0000_0000_0000_0000,
      16'b1000_0000_0000_0001,
      16'b1100_0000_0000_0011,
      16'b1110_0000_0000_0111,
      16'b1111_0000_0000_1111,
      16'b0111_1000_0001_1110,
      16'b0011_1100_0011_1100,
      16'b0001_1111_1111_1000,
      16'b0000_1111_1111_0000,
      16'b0000_0111_1110_0000,
      16'b0000_1111_1111_0000,
      16'b0001_1110_0111_1000,
      16'b0011_1100_0011_1100,
      16'b0111_1000_0001_1110,
      16'b1111_0000_0000_1111,
      16'b0000_0000_0000_0000},
   '{ // Ring
      16'b0000_0111_1110_0000,
      16'b0001_1111_1111_1000,
      16'b0011_1111_1111_1100,
      16'b0111_1111_1111_1110,
      16'b0111_1110_0111_1110,
      16'b1111_1100_0011_1111,
      16'b1111_1000_0001_1111,
      16'b1111_1000_0001_1111,
      16'b1111_1000_0001_1111,
      16'b1111_1000_0001_1111,
      16'b1111_1100_0011_1111,
      16'b0111_1110_0111_1110,
      16'b0111_1111_1111_1110,
      16'b0011_1111_1111_1100,
      16'b0001_1111_1111_1000,
      16'b0000_0111_1110_0000}
};

// Outline colour where a set pixel has a clear neighbour
localparam sprite_pkg::rgb_t edge_rgb [N_PATTERNS] = '{24'hff_ff_00, 24'hff_00_ff, 24'h00_ff_ff};

// Interior colour
localparam sprite_pkg::rgb_t fill_rgb [N_PATTERNS] = '{24'hff_00_00, 24'h00_c0_00, 24'h00_00_ff};

// File: source/sprite_pkg.sv
package sprite_pkg;

   typedef logic [23:0] rgb_t;            // Red 23:16, green 15:8, blue 7:0
   typedef logic [7:0]  bus_data_t;
   typedef logic [2:0]  reg_addr_t;

   // Sprite position, x in horizontal counts and y in lines
   typedef logic [15:0] coord_t;

   typedef logic [1:0]  pattern_name_t;

   // Row or pixel column inside one sprite
   typedef logic [3:0]  offset_t;

   // Host register map
   localparam reg_addr_t REG_COMMIT = 3'd0;   // Bit 0 set copies staging into a slot
   localparam reg_addr_t REG_SLOT   = 3'd1;
   localparam reg_addr_t REG_X_HI   = 3'd2;
   localparam reg_addr_t REG_X_LO   = 3'd3;
   localparam reg_addr_t REG_Y_HI   = 3'd4;
   localparam reg_addr_t REG_Y_LO   = 3'd5;
   localparam reg_addr_t REG_NAME   = 3'd6;
   localparam reg_addr_t REG_ENABLE = 3'd7;

   // Pixels per side; 2 * SPRITE_SIZE horizontal counts wide
   localparam int SPRITE_SIZE = 16;

   // Shown wherever no opaque sprite pixel lies
   localparam rgb_t BACKGROUND_RGB = 24'h10_20_40;

endpackage

// File: source/sprite_registers.sv
`timescale 1ns/1ps

module sprite_registers #(
   parameter int N_SLOTS = 8
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      chipselect,
   input  logic                      write,
   input  sprite_pkg::reg_addr_t     address,
   input  sprite_pkg::bus_data_t     writedata,
   output logic [N_SLOTS-1:0]        commit,
   output sprite_pkg::coord_t        staged_x,
   output sprite_pkg::coord_t        staged_y,
   output sprite_pkg::pattern_name_t staged_name,
   output logic                      staged_enable
);

   sprite_pkg::bus_data_t slot_q;
   sprite_pkg::bus_data_t x_hi;
   sprite_pkg::bus_data_t x_lo;
   sprite_pkg::bus_data_t y_hi;
   sprite_pkg::bus_data_t y_lo;
   logic                  bus_write;
   logic                  commit_write;
   logic [N_SLOTS-1:0]    commit_sel;

   assign bus_write    = chipselect && write;
   assign commit_write = bus_write && address == sprite_pkg::REG_COMMIT && writedata[0];

   // Slot number wraps onto the slots that exist
   always_comb begin
      commit_sel = '0;
      commit_sel[slot_q % N_SLOTS] = 1'b1;
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         slot_q        <= '0;
         x_hi          <= '0;
         x_lo          <= '0;
         y_hi          <= '0;
         y_lo          <= '0;
         staged_name   <= '0;
         staged_enable <= 1'b0;
      end else if (bus_write) begin
         case (address)
            sprite_pkg::REG_COMMIT: ;   // Only raises the commit strobe
            sprite_pkg::REG_SLOT:   slot_q <= writedata;
            sprite_pkg::REG_X_HI:   x_hi <= writedata;
            sprite_pkg::REG_X_LO:   x_lo <= writedata;
            sprite_pkg::REG_Y_HI:   y_hi <= writedata;
            sprite_pkg::REG_Y_LO:   y_lo <= writedata;
            sprite_pkg::REG_NAME:   staged_name <= writedata[1:0];
            sprite_pkg::REG_ENABLE: staged_enable <= writedata[0];
            default: ;
         endcase
      end
   end

   // One clock wide, one hot on the target slot
   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         commit <= '0;
      else if (commit_write)
         commit <= commit_sel;
      else
         commit <= '0;
   end

   assign staged_x = {x_hi, x_lo};
   assign staged_y = {y_hi, y_lo};

endmodule

// File: source/sprite_slot.sv
`timescale 1ns/1ps

module sprite_slot #(
   parameter int H_ACTIVE = video_timing_pkg::H_ACTIVE_DEFAULT,
   parameter int V_ACTIVE = video_timing_pkg::V_ACTIVE_DEFAULT
) (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      commit,
   input  sprite_pkg::coord_t        staged_x,
   input  sprite_pkg::coord_t        staged_y,
   input  sprite_pkg::pattern_name_t staged_name,
   input  logic                      staged_enable,
   input  video_timing_pkg::hcount_t hcount,
   input  video_timing_pkg::vcount_t vcount,
   output logic                      hit,
   output sprite_pkg::offset_t       row,
   output sprite_pkg::offset_t       col,
   output sprite_pkg::pattern_name_t name
);

   localparam int BOX_W = 2 * sprite_pkg::SPRITE_SIZE;   // In horizontal counts
   localparam int BOX_H = sprite_pkg::SPRITE_SIZE;

   sprite_pkg::coord_t        x_q;
   sprite_pkg::coord_t        y_q;
   sprite_pkg::pattern_name_t name_q;
   logic                      enable_q;
   logic [16:0]               dx;
   logic [16:0]               dy;
   logic                      visible;
   logic                      in_box;

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         enable_q <= 1'b0;
      else if (commit)
         enable_q <= staged_enable;
   end

   always_ff @(posedge clk) begin
      if (commit) begin
         x_q    <= staged_x;
         y_q    <= staged_y;
         name_q <= staged_name;
      end
   end

   // A position left of or above the box wraps to a large offset
   assign dx = {6'b0, hcount} - {1'b0, x_q};
   assign dy = {7'b0, vcount} - {1'b0, y_q};

   assign visible = hcount < H_ACTIVE && vcount < V_ACTIVE;
   assign in_box  = enable_q && visible && dx < BOX_W && dy < BOX_H;

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         hit <= 1'b0;
      else
         hit <= in_box;
   end

   always_ff @(posedge clk) begin
      row  <= dy[3:0];
      col  <= dx[4:1];   // Two counts per pixel
      name <= name_q;
   end

endmodule

// File: source/video_timing_pkg.sv
package video_timing_pkg;

   // One count per system clock, so two counts per pixel
   typedef logic [10:0] hcount_t;

   // One count per line
   typedef logic [9:0] vcount_t;

   // 640x480 at 60 Hz with a 50 MHz system clock
   localparam int H_ACTIVE_DEFAULT = 1280;   // 640 pixels
   localparam int H_FRONT_DEFAULT  = 32;
   localparam int H_SYNC_DEFAULT   = 192;
   localparam int H_BACK_DEFAULT   = 96;     // Line total 1600

   localparam int V_ACTIVE_DEFAULT = 480;
   localparam int V_FRONT_DEFAULT  = 10;
   localparam int V_SYNC_DEFAULT   = 2;
   localparam int V_BACK_DEFAULT   = 33;     // Field total 525

endpackage

// File: sprite_display.f
+incdir+source
source/video_timing_pkg.sv
source/sprite_pkg.sv
source/scan_timing.sv
source/sprite_registers.sv
source/sprite_slot.sv
source/sprite_compositor.sv
source/sprite_display.sv
verification/sprite_display_checker.sv
verification/sprite_display_tb.sv

// File: verification/sprite_display_checker.sv
`timescale 1ns/1ps

module sprite_display_checker (
   input logic       clk,
   input logic       reset,
   input logic [7:0] VGA_R,
   input logic [7:0] VGA_G,
   input logic [7:0] VGA_B,
   input logic       VGA_CLK,
   input logic       VGA_HS,
   input logic       VGA_BLANK_n
);

   int failure_count = 0;   // Assertion failures so far

   // Pixel clock is hcount bit 0, so it flips on every system clock
   clk_toggles: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> VGA_CLK != $past(VGA_CLK))
      else begin
         $error("VGA_CLK held its level for two cycles");
         failure_count++;
      end

   rgb_dark_in_blank: assert property (@(posedge clk) disable iff (reset)
      !VGA_BLANK_n |-> {VGA_R, VGA_G, VGA_B} == 24'h0)
      else begin
         $error("RGB is not zero while VGA_BLANK_n is low");
         failure_count++;
      end

   // Horizontal sync lies outside the active area
   blank_in_hsync: assert property (@(posedge clk) disable iff (reset)
      !VGA_HS |-> !VGA_BLANK_n)
      else begin
         $error("VGA_BLANK_n is high during horizontal sync");
         failure_count++;
      end

endmodule

bind sprite_display sprite_display_checker checker_inst (
   .clk(clk), .reset(reset), .VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B),
   .VGA_CLK(VGA_CLK), .VGA_HS(VGA_HS), .VGA_BLANK_n(VGA_BLANK_n)
);

// File: verification/sprite_display_tb.sv
`timescale 1ns/1ps

module sprite_display_tb;

   localparam int N_SLOTS         = 8;
   localparam int H_ACTIVE        = 320;
   localparam int H_FRONT         = 8;
   localparam int H_SYNC          = 24;
   localparam int H_BACK          = 16;
   localparam int V_ACTIVE        = 60;
   localparam int V_FRONT         = 2;
   localparam int V_SYNC          = 4;
   localparam int V_BACK          = 4;
   localparam int H_TOTAL         = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL         = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
   localparam int FRAME_CYCLES    = H_TOTAL * V_TOTAL;
   localparam int CLK_PERIOD      = 8;
   localparam int RESET_CYCLES    = 10;
   localparam int N_SETUPS        = 8;
   localparam int N_RANDOM_ROUNDS = 2;
   localparam int FRAMES_USED     = 4 + N_SETUPS + N_RANDOM_ROUNDS;   // Sync pair, lead-in, tail
   localparam int WATCHDOG_NS     = 2 * FRAME_CYCLES * FRAMES_USED * CLK_PERIOD;

   `include "sprite_patterns.svh"

   typedef struct packed {
      logic [7:0]  slot;
      logic [15:0] x;
      logic [15:0] y;
      logic [1:0]  name;
      logic        enable;
      logic        commit;
   } setup_t;

   localparam setup_t SETUPS [N_SETUPS] = '{
      '{8'd0,  16'd40,  16'd8,  2'd0, 1'b1, 1'b1},   // Ship alone
      '{8'd3,  16'd120, 16'd20, 2'd1, 1'b1, 1'b1},
      '{8'd7,  16'd300, 16'd50, 2'd2, 1'b1, 1'b1},   // Clipped at right and bottom
      '{8'd2,  16'd200, 16'd30, 2'd2, 1'b1, 1'b0},   // Staged only
      '{8'd5,  16'd130, 16'd26, 2'd2, 1'b1, 1'b1},   // On top of slot 3
      '{8'd1,  16'd136, 16'd24, 2'd0, 1'b1, 1'b1},   // Beneath slots 3 and 5
      '{8'd3,  16'd120, 16'd20, 2'd1, 1'b0, 1'b1},   // Bird removed
      '{8'd10, 16'd0,   16'd0,  2'd1, 1'b1, 1'b1}    // Slot number wraps to 2
   };

   logic                  clk = 1'b0;
   logic                  reset;
   logic                  chipselect;
   logic                  write;
   sprite_pkg::reg_addr_t address;
   sprite_pkg::bus_data_t writedata;
   logic [7:0]            VGA_R;
   logic [7:0]            VGA_G;
   logic [7:0]            VGA_B;
   logic                  VGA_CLK;
   logic                  VGA_HS;
   logic                  VGA_VS;
   logic                  VGA_BLANK_n;

   // Register map model
   logic [7:0]  staged_slot;
   logic [15:0] staged_x;
   logic [15:0] staged_y;
   logic [1:0]  staged_name;
   logic        staged_enable;
   int          slot_x [N_SLOTS];
   int          slot_y [N_SLOTS];
   int          slot_name [N_SLOTS];
   logic        slot_en [N_SLOTS];

   // The pos values hold the scan position the outputs describe
   int     cur_h = 0;
   int     cur_v = 0;
   int     hist_h [3];
   int     hist_v [3];
   int     run_count = 0;
   int     pos_h = 0;
   int     pos_v = 0;
   logic   pos_valid = 1'b0;
   logic   count_en;
   int     hs_low = 0;
   int     vs_low = 0;
   int     blank_high = 0;
   int     checks_done = 0;
   integer seed = 32'h9802_21be;

   always #(CLK_PERIOD / 2) clk = ~clk;

   sprite_display #(
      .N_SLOTS(N_SLOTS),
      .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
      .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
   ) sprite_display_inst (
      .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
      .address(address), .writedata(writedata),
      .VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B), .VGA_CLK(VGA_CLK),
      .VGA_HS(VGA_HS), .VGA_VS(VGA_VS), .VGA_BLANK_n(VGA_BLANK_n)
   );

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("CHECK FAILED at %0t ns: %s is %h, expected %h (scan h=%0d v=%0d)",
                  $time, what, got, exp, pos_h, pos_v);
         $display("tests failed");
         $fatal(1, "Stopped at the first mismatch");
      end
   endtask

   function automatic void model_write(input sprite_pkg::reg_addr_t a,
                                       input sprite_pkg::bus_data_t d);
      int idx;
      idx = staged_slot % N_SLOTS;
      case (a)
         sprite_pkg::REG_COMMIT: begin
            if (d[0]) begin
               slot_x[idx]    = staged_x;
               slot_y[idx]    = staged_y;
               slot_name[idx] = staged_name;
               slot_en[idx]   = staged_enable;
            end
         end
         sprite_pkg::REG_SLOT:   staged_slot = d;
         sprite_pkg::REG_X_HI:   staged_x[15:8] = d;
         sprite_pkg::REG_X_LO:   staged_x[7:0] = d;
         sprite_pkg::REG_Y_HI:   staged_y[15:8] = d;
         sprite_pkg::REG_Y_LO:   staged_y[7:0] = d;
         sprite_pkg::REG_NAME:   staged_name = d[1:0];
         default:                staged_enable = d[0];
      endcase
   endfunction

   task automatic write_register(input sprite_pkg::reg_addr_t a, input sprite_pkg::bus_data_t d);
      @(posedge clk);
      chipselect <= 1'b1;
      write      <= 1'b1;
      address    <= a;
      writedata  <= d;
      model_write(a, d);
   endtask

   task automatic bus_idle;
      @(posedge clk);
      chipselect <= 1'b0;
      write      <= 1'b0;
   endtask

   task automatic apply_setup(input setup_t s);
      write_register(sprite_pkg::REG_SLOT, s.slot);
      write_register(sprite_pkg::REG_X_HI, s.x[15:8]);
      write_register(sprite_pkg::REG_X_LO, s.x[7:0]);
      write_register(sprite_pkg::REG_Y_HI, s.y[15:8]);
      write_register(sprite_pkg::REG_Y_LO, s.y[7:0]);
      write_register(sprite_pkg::REG_NAME, {6'b0, s.name});
      write_register(sprite_pkg::REG_ENABLE, {7'b0, s.enable});
      write_register(sprite_pkg::REG_COMMIT, {7'b0, s.commit});   // Bit 0 clear is no commit
      bus_idle();
   endtask

   function automatic setup_t random_setup(input int slot);
      setup_t      s;
      int unsigned r;
      s.slot   = slot;
      r        = $random(seed);
      s.x      = r % (H_ACTIVE + 16);   // Some boxes run off the right edge
      r        = $random(seed);
      s.y      = r % (V_ACTIVE + 8);
      r        = $random(seed);
      s.name   = r % N_PATTERNS;
      s.enable = r[5:4] != 2'b00;
      s.commit = 1'b1;
      return s;
   endfunction

   // Colour of an active pixel from the slot model and the pattern tables
   function automatic sprite_pkg::rgb_t expected_rgb(input int h, input int v);
      int          sel;
      int          row;
      int          col;
      logic [15:0] bits;
      logic        pixel;
      logic        left;
      logic        right;
      sel = -1;
      for (int i = 0; i < N_SLOTS; i++) begin
         if (slot_en[i] && h >= slot_x[i] && h < slot_x[i] + 2 * sprite_pkg::SPRITE_SIZE
             && v >= slot_y[i] && v < slot_y[i] + sprite_pkg::SPRITE_SIZE)
            sel = i;   // Last one found is the highest index
      end
      if (sel < 0 || slot_name[sel] >= N_PATTERNS)
         return sprite_pkg::BACKGROUND_RGB;
      row   = v - slot_y[sel];
      col   = (h - slot_x[sel]) / 2;
      bits  = pattern_rows[slot_name[sel]][row];
      pixel = bits[15 - col];
      left  = (col > 0) ? bits[16 - col] : 1'b0;
      right = (col < 15) ? bits[14 - col] : 1'b0;
      if (!pixel)
         return sprite_pkg::BACKGROUND_RGB;
      else if (left && right)
         return fill_rgb[slot_name[sel]];
      else
         return edge_rgb[slot_name[sel]];
   endfunction

   task automatic check_outputs;
      logic             exp_hs;
      logic             exp_vs;
      logic             exp_blank;
      sprite_pkg::rgb_t exp_rgb;
      exp_hs    = !(pos_h >= H_ACTIVE + H_FRONT && pos_h < H_ACTIVE + H_FRONT + H_SYNC);
      exp_vs    = !(pos_v >= V_ACTIVE + V_FRONT && pos_v < V_ACTIVE + V_FRONT + V_SYNC);
      exp_blank = pos_h < H_ACTIVE && pos_v < V_ACTIVE;
      exp_rgb   = exp_blank ? expected_rgb(pos_h, pos_v) : 24'h0;
      check_value("VGA_HS", VGA_HS, exp_hs);
      check_value("VGA_VS", VGA_VS, exp_vs);
      check_value("VGA_BLANK_n", VGA_BLANK_n, exp_blank);
      check_value("RGB", {VGA_R, VGA_G, VGA_B}, exp_rgb);
      check_value("VGA_CLK", VGA_CLK, cur_h % 2);   // Current count, not the delayed one
      checks_done++;
      if (count_en) begin
         hs_low     += !VGA_HS;
         vs_low     += !VGA_VS;
         blank_high += VGA_BLANK_n;
      end
      if (sprite_display_inst.checker_inst.failure_count != 0) begin
         $display("A bound assertion on the VGA outputs failed at %0t ns", $time);
         $display("tests failed");
         $fatal(1, "Assertion failure");
      end
   endtask

   // Outputs lag the counters by two clocks
   always @(negedge clk) begin
      if (reset) begin
         cur_h     = 0;
         cur_v     = 0;
         run_count = 0;
         pos_valid = 1'b0;
      end else begin
         if (run_count > 0) begin
            cur_h = cur_h + 1;
            if (cur_h == H_TOTAL) begin
               cur_h = 0;
               cur_v = (cur_v == V_TOTAL - 1) ? 0 : cur_v + 1;
            end
         end
         hist_h[2] = hist_h[1];
         hist_v[2] = hist_v[1];
         hist_h[1] = hist_h[0];
         hist_v[1] = hist_v[0];
         hist_h[0] = cur_h;
         hist_v[0] = cur_v;
         if (run_count < 3)
            run_count++;
         pos_valid = run_count >= 3;
         pos_h     = hist_h[2];
         pos_v     = hist_v[2];
         if (pos_valid)
            check_outputs();
      end
   end

   task automatic wait_for_position(input int h, input int v);
      do
         @(posedge clk);
      while (!(pos_valid && pos_h == h && pos_v == v));
   endtask

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns before the last frame was checked", WATCHDOG_NS);
      $display("tests failed");
      $fatal(1, "Timeout");
   end

   initial begin
      reset         = 1'b1;
      chipselect    = 1'b0;
      write         = 1'b0;
      address       = '0;
      writedata     = '0;
      count_en      = 1'b0;
      staged_slot   = '0;
      staged_x      = '0;
      staged_y      = '0;
      staged_name   = '0;
      staged_enable = 1'b0;
      for (int i = 0; i < N_SLOTS; i++) begin
         slot_x[i]    = 0;
         slot_y[i]    = 0;
         slot_name[i] = 0;
         slot_en[i]   = 1'b0;
      end

      repeat (RESET_CYCLES - 1) @(posedge clk);
      @(negedge clk);
      check_value("VGA_HS in reset", VGA_HS, 1'b1);
      check_value("VGA_VS in reset", VGA_VS, 1'b1);
      check_value("VGA_BLANK_n in reset", VGA_BLANK_n, 1'b0);
      check_value("RGB in reset", {VGA_R, VGA_G, VGA_B}, 24'h0);
      check_value("VGA_CLK in reset", VGA_CLK, 1'b0);
      @(posedge clk);
      reset <= 1'b0;

      // Sync widths counted over two empty frames
      wait_for_position(0, 0);
      count_en = 1'b1;
      wait_for_position(0, 0);
      wait_for_position(0, 0);
      count_en = 1'b0;
      check_value("HS low cycles", hs_low, 2 * V_TOTAL * H_SYNC);
      check_value("VS low cycles", vs_low, 2 * V_SYNC * H_TOTAL);
      check_value("BLANK_n high cycles", blank_high, 2 * V_ACTIVE * H_ACTIVE);

      // Changes go in during vertical blanking before the frame they affect
      for (int i = 0; i < N_SETUPS; i++) begin
         wait_for_position(0, V_ACTIVE);
         apply_setup(SETUPS[i]);
      end
      for (int r = 0; r < N_RANDOM_ROUNDS; r++) begin
         wait_for_position(0, V_ACTIVE);
         for (int s = 0; s < N_SLOTS; s++)
            apply_setup(random_setup(s));
      end
      wait_for_position(0, V_ACTIVE);

      if (checks_done > 0 && sprite_display_inst.checker_inst.failure_count == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("tests failed");
         $fatal(1, "No output was checked or an assertion failed");
      end
   end

endmodule
